// ==== common/mandel_defs.svh ====
`ifndef MANDEL_DEFS_SVH
`define MANDEL_DEFS_SVH

// Fixed point, signed 4.23
`define FIX_WIDTH 27
`define FIX_FRAC 23

// Escape bounds in 4.23
// 4.0 on the squared magnitude
`define ESCAPE_MAG (27'sh2000000)
// 2.0 on each component
`define ESCAPE_COMP (27'sh1000000)

// Stored pixel is RGB332
`define COLOR_WIDTH 8

`define ITER_MAX_DEFAULT 1000

// Horizontal phase lengths, in clocks
`define H_ACTIVE_DEFAULT 640
`define H_FRONT_DEFAULT 16
`define H_PULSE_DEFAULT 96
`define H_BACK_DEFAULT 48

// Vertical phase lengths, in lines
`define V_ACTIVE_DEFAULT 480
`define V_FRONT_DEFAULT 10
`define V_PULSE_DEFAULT 2
`define V_BACK_DEFAULT 33

// View window, real axis from -2.0, imaginary row 240 on zero
`define X_START_DEFAULT (-27'sd16777216)
`define Y_START_DEFAULT (27'sd9360000)
`define STEP_DEFAULT (27'sd39000)

`endif

// ==== common/mandel_pkg.sv ====
`include "mandel_defs.svh"

package mandel_pkg;

	// Signed 4.23 value
	typedef logic signed [`FIX_WIDTH-1:0] fix_t;

	// RGB332 pixel, red in the top bits
	typedef logic [`COLOR_WIDTH-1:0] color_t;

	// Screen coordinate or phase counter
	typedef logic [9:0] coord_t;

	// Escape iterator states
	typedef enum logic [1:0] {
		ITER_IDLE,
		ITER_CALC,
		ITER_DONE
	} iter_state_t;

	// Render walker states
	typedef enum logic {
		RENDER_CALC,
		RENDER_DONE
	} render_state_t;

	// Sync phases, same order for both machines
	// Order matters, next phase is the enum plus one
	typedef enum logic [1:0] {
		ACTIVE,
		FRONT,
		PULSE,
		BACK
	} sync_phase_t;

endpackage

// ==== render/escape_iterator.sv ====
`timescale 1ns/1ns
`include "mandel_defs.svh"

module escape_iterator import mandel_pkg::*; #(
	parameter int ITER_MAX = `ITER_MAX_DEFAULT,
	localparam int CNT_W = $clog2(ITER_MAX) + 1
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             iter_start,
	input  logic             iter_ack,
	input  fix_t             c_re,
	input  fix_t             c_im,
	output logic             iter_ready,
	output logic             iter_valid,
	output logic [CNT_W-1:0] iter_count
);

	iter_state_t state;

	// z and the held c
	fix_t zr;
	fix_t zi;
	fix_t cr;
	fix_t ci;

	// Products of the current z
	fix_t zr_sq;
	fix_t zi_sq;
	fix_t zr_zi;
	fix_t z_mag_sq;

	// z squared plus c
	fix_t zr_next;
	fix_t zi_next;
	logic escape;

	// 4.23 multiply, sign bit kept, integer overflow bits dropped
	function automatic fix_t fix_mul(input fix_t a, input fix_t b);
		logic signed [2*`FIX_WIDTH-1:0] p;
		p = a * b;
		fix_mul = {p[2*`FIX_WIDTH-1], p[`FIX_WIDTH+`FIX_FRAC-2:`FIX_FRAC]};
	endfunction

	assign zr_sq = fix_mul(zr, zr);
	assign zi_sq = fix_mul(zi, zi);
	assign zr_zi = fix_mul(zr, zi);
	assign z_mag_sq = zr_sq + zi_sq;

	assign zr_next = zr_sq - zi_sq + cr;
	assign zi_next = (zr_zi <<< 1) + ci;

	// Outside radius 2, either component out of range, or out of steps
	assign escape = (z_mag_sq > `ESCAPE_MAG)
		|| (iter_count == CNT_W'(ITER_MAX - 1))
		|| (zr_next > `ESCAPE_COMP) || (zr_next < -`ESCAPE_COMP)
		|| (zi_next > `ESCAPE_COMP) || (zi_next < -`ESCAPE_COMP);

	assign iter_ready = (state == ITER_IDLE);
	assign iter_valid = (state == ITER_DONE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ITER_IDLE;
		end else begin
			case (state)
				ITER_IDLE: begin
					if (iter_start) begin
						state <= ITER_CALC;
					end
				end
				ITER_CALC: begin
					if (escape) begin
						state <= ITER_DONE;
					end
				end
				ITER_DONE: begin
					// Hold the count until the consumer takes it
					if (iter_ack) begin
						state <= ITER_IDLE;
					end
				end
				default: begin
					state <= ITER_IDLE;
				end
			endcase
		end
	end

	// Datapath, one step per clock while in CALC
	always_ff @(posedge clk) begin
		if (state == ITER_IDLE && iter_start) begin
			cr <= c_re;
			ci <= c_im;
			zr <= '0;
			zi <= '0;
			iter_count <= '0;
		end else if (state == ITER_CALC) begin
			zr <= zr_next;
			zi <= zi_next;
			// Escaping step counted too
			iter_count <= iter_count + 1'b1;
		end
	end

	// Requester waits for IDLE before a new start
	assert property (@(posedge clk) disable iff (reset)
		iter_start |-> state == ITER_IDLE);

endmodule

// ==== render/render_control.sv ====
`timescale 1ns/1ns
`include "mandel_defs.svh"

module render_control import mandel_pkg::*; #(
	parameter int FRAME_W = `H_ACTIVE_DEFAULT,
	parameter int FRAME_H = `V_ACTIVE_DEFAULT,
	parameter int ITER_MAX = `ITER_MAX_DEFAULT,
	parameter fix_t X_START = `X_START_DEFAULT,
	parameter fix_t Y_START = `Y_START_DEFAULT,
	parameter fix_t STEP = `STEP_DEFAULT,
	localparam int CNT_W = $clog2(ITER_MAX) + 1,
	localparam int ADDR_W = $clog2(FRAME_W * FRAME_H)
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              iter_ready,
	input  logic              iter_valid,
	input  logic [CNT_W-1:0]  iter_count,
	input  color_t            pixel_color,
	output logic              iter_start,
	output logic              iter_ack,
	output fix_t              c_re,
	output fix_t              c_im,
	output logic              wr_en,
	output logic [ADDR_W-1:0] wr_addr,
	output color_t            wr_color,
	output logic              render_done
);

	render_state_t state;

	// Current pixel position
	coord_t col;
	coord_t row;

	// Request outstanding at the iterator
	logic busy;
	logic last_col;
	logic last_pixel;

	assign last_col = (col == coord_t'(FRAME_W - 1));
	assign last_pixel = last_col && (row == coord_t'(FRAME_H - 1));

	// Result taken as soon as it shows up
	assign iter_ack = busy;

	////////////////////////////////////////
	// Pixel walker
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= RENDER_CALC;
			busy <= 1'b0;
			iter_start <= 1'b0;
			wr_en <= 1'b0;
			render_done <= 1'b0;
			col <= '0;
			row <= '0;
			c_re <= X_START;
			c_im <= Y_START;
		end else begin
			// Strobes default low
			iter_start <= 1'b0;
			wr_en <= 1'b0;
			case (state)
				RENDER_CALC: begin
					if (!busy && iter_ready) begin
						// Hand over the current coordinate
						iter_start <= 1'b1;
						busy <= 1'b1;
					end else if (busy && iter_valid) begin
						// Result in, write next cycle
						busy <= 1'b0;
						wr_en <= 1'b1;
						if (last_pixel) begin
							state <= RENDER_DONE;
						end
						// Step along the row, wrap to the next row down
						if (last_col) begin
							col <= '0;
							row <= row + 1'b1;
							c_re <= X_START;
							c_im <= c_im - STEP;
						end else begin
							col <= col + 1'b1;
							c_re <= c_re + STEP;
						end
					end
				end
				RENDER_DONE: begin
					// Last write lands this cycle
					render_done <= 1'b1;
				end
				default: begin
					state <= RENDER_CALC;
				end
			endcase
		end
	end

	// Write payload, raster index of the finished pixel
	always_ff @(posedge clk) begin
		if (iter_valid) begin
			wr_addr <= ADDR_W'(row * FRAME_W + col);
			wr_color <= pixel_color;
		end
	end

	// Writes stay inside the frame
	assert property (@(posedge clk) disable iff (reset)
		wr_en |-> wr_addr < FRAME_W * FRAME_H);

	// Iterator never returns a count outside 1..ITER_MAX
	assert property (@(posedge clk) disable iff (reset)
		iter_valid |-> (iter_count >= 1) && (iter_count <= ITER_MAX));

endmodule

// ==== verilog/color_map.sv ====
`timescale 1ns/1ns
`include "mandel_defs.svh"

module color_map import mandel_pkg::*; #(
	parameter int ITER_MAX = `ITER_MAX_DEFAULT,
	localparam int CNT_W = $clog2(ITER_MAX) + 1
) (
	input  logic [CNT_W-1:0] iter_count,
	output color_t           pixel_color
);

	// Palette bands by power-of-two fractions of ITER_MAX
	always_comb begin
		if (iter_count >= ITER_MAX) begin
			// Inside the set
			pixel_color = 8'b000_000_00;
		end else if (iter_count >= (ITER_MAX >> 2)) begin
			// Upper half shares this colour
			pixel_color = 8'b011_001_00;
		end else if (iter_count >= (ITER_MAX >> 3)) begin
			pixel_color = 8'b101_010_01;
		end else if (iter_count >= (ITER_MAX >> 4)) begin
			pixel_color = 8'b011_001_01;
		end else if (iter_count >= (ITER_MAX >> 5)) begin
			pixel_color = 8'b001_001_01;
		end else if (iter_count >= (ITER_MAX >> 6)) begin
			pixel_color = 8'b011_010_10;
		end else begin
			// Fast escapes, far from the set
			pixel_color = 8'b010_100_10;
		end
	end

endmodule

// ==== verilog/frame_buffer.sv ====
`timescale 1ns/1ns
`include "mandel_defs.svh"

module frame_buffer import mandel_pkg::*; #(
	parameter int DEPTH = `H_ACTIVE_DEFAULT * `V_ACTIVE_DEFAULT,
	localparam int ADDR_W = $clog2(DEPTH)
) (
	input  logic              clk,
	input  logic              wr_en,
	input  logic [ADDR_W-1:0] wr_addr,
	input  color_t            wr_color,
	input  logic [ADDR_W-1:0] rd_addr,
	output color_t            rd_color
);

	// One RGB332 word per pixel
	color_t mem [DEPTH];

	// Write port from the renderer
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_color;
		end
	end

	// Read port for the display, old data on a collision
	always_ff @(posedge clk) begin
		rd_color <= mem[rd_addr];
	end

endmodule

// ==== vga/vga_timing.sv ====
`timescale 1ns/1ns
`include "mandel_defs.svh"

module vga_timing import mandel_pkg::*; #(
	parameter int H_ACTIVE = `H_ACTIVE_DEFAULT,
	parameter int H_FRONT = `H_FRONT_DEFAULT,
	parameter int H_PULSE = `H_PULSE_DEFAULT,
	parameter int H_BACK = `H_BACK_DEFAULT,
	parameter int V_ACTIVE = `V_ACTIVE_DEFAULT,
	parameter int V_FRONT = `V_FRONT_DEFAULT,
	parameter int V_PULSE = `V_PULSE_DEFAULT,
	parameter int V_BACK = `V_BACK_DEFAULT
) (
	input  logic       clk,
	input  logic       reset,
	input  color_t     rd_color,
	output coord_t     rd_x,
	output coord_t     rd_y,
	output logic       hsync,
	output logic       vsync,
	output logic       blank_n,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	sync_phase_t h_phase;
	sync_phase_t h_phase_nx;
	sync_phase_t v_phase;
	sync_phase_t v_phase_nx;

	// Position inside the current phase
	coord_t h_cnt;
	coord_t h_cnt_nx;
	coord_t v_cnt;
	coord_t v_cnt_nx;

	logic h_last;
	logic v_last;
	logic line_end;
	logic active;
	// Active flag, aligned with buffer read data
	logic active_d;

	// Length of a phase for either machine
	function automatic int phase_len(input sync_phase_t p, input int act, input int fr,
			input int pu, input int bk);
		case (p)
			ACTIVE: phase_len = act;
			FRONT: phase_len = fr;
			PULSE: phase_len = pu;
			default: phase_len = bk;
		endcase
	endfunction

	assign h_last = (h_cnt == coord_t'(phase_len(h_phase, H_ACTIVE, H_FRONT, H_PULSE,
		H_BACK) - 1));
	assign v_last = (v_cnt == coord_t'(phase_len(v_phase, V_ACTIVE, V_FRONT, V_PULSE,
		V_BACK) - 1));

	// Last clock of the back porch closes the line
	assign line_end = h_last && (h_phase == BACK);

	////////////////////////////////////////
	// Phase machines, next values
	////////////////////////////////////////
	always_comb begin
		h_phase_nx = h_phase;
		h_cnt_nx = h_cnt + 1'b1;
		if (h_last) begin
			h_cnt_nx = '0;
			h_phase_nx = sync_phase_t'(h_phase + 2'd1);
		end
		// Vertical moves once per line
		v_phase_nx = v_phase;
		v_cnt_nx = v_cnt;
		if (line_end) begin
			if (v_last) begin
				v_cnt_nx = '0;
				v_phase_nx = sync_phase_t'(v_phase + 2'd1);
			end else begin
				v_cnt_nx = v_cnt + 1'b1;
			end
		end
	end

	assign active = (h_phase == ACTIVE) && (v_phase == ACTIVE);

	// Read address for the pixel now being scanned
	assign rd_x = (h_phase == ACTIVE) ? h_cnt : '0;
	assign rd_y = (v_phase == ACTIVE) ? v_cnt : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			h_phase <= ACTIVE;
			v_phase <= ACTIVE;
			h_cnt <= '0;
			v_cnt <= '0;
			hsync <= 1'b1;
			vsync <= 1'b1;
			active_d <= 1'b0;
			blank_n <= 1'b0;
			red <= '0;
			green <= '0;
			blue <= '0;
		end else begin
			h_phase <= h_phase_nx;
			v_phase <= v_phase_nx;
			h_cnt <= h_cnt_nx;
			v_cnt <= v_cnt_nx;
			// Syncs from next phase, so they line up with the phase itself
			hsync <= (h_phase_nx != PULSE);
			vsync <= (v_phase_nx != PULSE);

			////////////////////////////////////////
			// Colour out, two clocks behind rd_x/rd_y
			////////////////////////////////////////
			active_d <= active;
			blank_n <= active_d;
			// RGB332 fields to the top bits, zero fill
			red <= active_d ? {rd_color[7:5], 5'b0} : 8'd0;
			green <= active_d ? {rd_color[4:2], 5'b0} : 8'd0;
			blue <= active_d ? {rd_color[1:0], 6'b0} : 8'd0;
		end
	end

	// Counters never run past their phase
	assert property (@(posedge clk) disable iff (reset)
		h_cnt < phase_len(h_phase, H_ACTIVE, H_FRONT, H_PULSE, H_BACK));
	assert property (@(posedge clk) disable iff (reset)
		v_cnt < phase_len(v_phase, V_ACTIVE, V_FRONT, V_PULSE, V_BACK));

	// Sync pulse only inside the PULSE phase
	assert property (@(posedge clk) disable iff (reset)
		!hsync |-> h_phase == PULSE);

endmodule

// ==== verilog/mandel_top.sv ====
`timescale 1ns/1ns
`include "mandel_defs.svh"

module mandel_top import mandel_pkg::*; #(
	parameter int H_ACTIVE = `H_ACTIVE_DEFAULT,
	parameter int H_FRONT = `H_FRONT_DEFAULT,
	parameter int H_PULSE = `H_PULSE_DEFAULT,
	parameter int H_BACK = `H_BACK_DEFAULT,
	parameter int V_ACTIVE = `V_ACTIVE_DEFAULT,
	parameter int V_FRONT = `V_FRONT_DEFAULT,
	parameter int V_PULSE = `V_PULSE_DEFAULT,
	parameter int V_BACK = `V_BACK_DEFAULT,
	parameter int ITER_MAX = `ITER_MAX_DEFAULT,
	parameter fix_t X_START = `X_START_DEFAULT,
	parameter fix_t Y_START = `Y_START_DEFAULT,
	parameter fix_t STEP = `STEP_DEFAULT,
	// Frame is the active area
	localparam int FRAME_W = H_ACTIVE,
	localparam int FRAME_H = V_ACTIVE,
	localparam int CNT_W = $clog2(ITER_MAX) + 1,
	localparam int ADDR_W = $clog2(FRAME_W * FRAME_H)
) (
	input  logic       clk,
	input  logic       reset,
	output logic       render_done,
	output logic       hsync,
	output logic       vsync,
	output logic       blank_n,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	// Iterator handshake
	logic iter_start;
	logic iter_ack;
	logic iter_ready;
	logic iter_valid;
	logic [CNT_W-1:0] iter_count;
	fix_t c_re;
	fix_t c_im;
	color_t pixel_color;

	// Buffer ports
	logic wr_en;
	logic [ADDR_W-1:0] wr_addr;
	color_t wr_color;
	logic [ADDR_W-1:0] rd_addr;
	color_t rd_color;
	coord_t rd_x;
	coord_t rd_y;

	render_control #(
		.FRAME_W(FRAME_W), .FRAME_H(FRAME_H), .ITER_MAX(ITER_MAX),
		.X_START(X_START), .Y_START(Y_START), .STEP(STEP)
	) u_render_control (
		.clk(clk), .reset(reset),
		.iter_ready(iter_ready), .iter_valid(iter_valid), .iter_count(iter_count),
		.pixel_color(pixel_color), .iter_start(iter_start), .iter_ack(iter_ack),
		.c_re(c_re), .c_im(c_im),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_color(wr_color),
		.render_done(render_done)
	);

	escape_iterator #(.ITER_MAX(ITER_MAX)) u_escape_iterator (
		.clk(clk), .reset(reset),
		.iter_start(iter_start), .iter_ack(iter_ack), .c_re(c_re), .c_im(c_im),
		.iter_ready(iter_ready), .iter_valid(iter_valid), .iter_count(iter_count)
	);

	color_map #(.ITER_MAX(ITER_MAX)) u_color_map (
		.iter_count(iter_count), .pixel_color(pixel_color)
	);

	// Display reads by the same raster rule as the writer
	assign rd_addr = ADDR_W'(rd_y * FRAME_W + rd_x);

	frame_buffer #(.DEPTH(FRAME_W * FRAME_H)) u_frame_buffer (
		.clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_color(wr_color),
		.rd_addr(rd_addr), .rd_color(rd_color)
	);

	vga_timing #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_PULSE(H_PULSE), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_PULSE(V_PULSE), .V_BACK(V_BACK)
	) u_vga_timing (
		.clk(clk), .reset(reset), .rd_color(rd_color), .rd_x(rd_x), .rd_y(rd_y),
		.hsync(hsync), .vsync(vsync), .blank_n(blank_n),
		.red(red), .green(green), .blue(blue)
	);

endmodule

// ==== bench/tb_mandel.sv ====
`timescale 1ns/1ns
`include "mandel_defs.svh"

module tb_mandel import mandel_pkg::*;;

	// Small frame, 24 clocks per line, 17 lines per frame
	localparam int H_ACTIVE = 16;
	localparam int V_ACTIVE = 12;
	localparam int LINE_CYCLES = 16 + 2 + 3 + 3;
	localparam int FRAME_LINES = 12 + 1 + 2 + 2;
	localparam int FRAME_CYCLES = LINE_CYCLES * FRAME_LINES;
	localparam int PIXELS = H_ACTIVE * V_ACTIVE;
	localparam int ITER_MAX = 64;

	// Window in 4.23, step of 3/16
	localparam int STEP_FIX = 3 << (`FIX_FRAC - 4);
	localparam int X_START_FIX = -(2 << `FIX_FRAC);
	localparam int Y_START_FIX = 6 * STEP_FIX;
	localparam fix_t MAG_LIMIT = fix_t'(4 << `FIX_FRAC);
	localparam fix_t COMP_LIMIT = fix_t'(2 << `FIX_FRAC);

	// Two full renders, since the restart renders again, plus frames and slack
	localparam int RENDER_CYCLES = PIXELS * (ITER_MAX + 4);
	localparam int CYCLE_LIMIT = 2 * RENDER_CYCLES + 8 * FRAME_CYCLES + 1000;

	logic clk;
	logic reset;
	logic render_done;
	logic hsync;
	logic vsync;
	logic blank_n;
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	integer seed;
	logic monitor_on = 1'b0;
	logic done_seen = 1'b0;

	// Expected and captured frames as {red, green, blue}
	logic [23:0] expected_rgb [PIXELS];
	logic [23:0] captured [PIXELS];

	mandel_top #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(2), .H_PULSE(3), .H_BACK(3),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(1), .V_PULSE(2), .V_BACK(2),
		.ITER_MAX(ITER_MAX),
		.X_START(fix_t'(X_START_FIX)), .Y_START(fix_t'(Y_START_FIX)),
		.STEP(fix_t'(STEP_FIX))
	) u_dut (
		.clk(clk), .reset(reset), .render_done(render_done),
		.hsync(hsync), .vsync(vsync), .blank_n(blank_n),
		.red(red), .green(green), .blue(blue)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Keep sign and product bits 48 to 23
	function automatic fix_t truncate_product(input fix_t a, input fix_t b);
		logic signed [2*`FIX_WIDTH-1:0] wide;
		wide = a * b;
		return {wide[2*`FIX_WIDTH-1], wide[`FIX_WIDTH+`FIX_FRAC-2:`FIX_FRAC]};
	endfunction

	// Escape-time count, escaping step included
	function automatic int escape_count(input fix_t cr, input fix_t ci);
		fix_t zr;
		fix_t zi;
		fix_t zr_sq;
		fix_t zi_sq;
		fix_t zr_zi;
		fix_t mag;
		fix_t zr_n;
		fix_t zi_n;
		int count;
		logic stop;
		zr = '0;
		zi = '0;
		count = 0;
		stop = 1'b0;
		while (!stop) begin
			zr_sq = truncate_product(zr, zr);
			zi_sq = truncate_product(zi, zi);
			zr_zi = truncate_product(zr, zi);
			mag = zr_sq + zi_sq;
			zr_n = zr_sq - zi_sq + cr;
			zi_n = (zr_zi <<< 1) + ci;
			stop = (mag > MAG_LIMIT) || (count == ITER_MAX - 1)
				|| (zr_n > COMP_LIMIT) || (zr_n < -COMP_LIMIT)
				|| (zi_n > COMP_LIMIT) || (zi_n < -COMP_LIMIT);
			zr = zr_n;
			zi = zi_n;
			count++;
		end
		return count;
	endfunction

	// Palette bands by ITER_MAX shifted right
	function automatic color_t palette(input int count);
		if (count >= ITER_MAX) return 8'b000_000_00;
		if (count >= (ITER_MAX >> 1)) return 8'b011_001_00;
		if (count >= (ITER_MAX >> 2)) return 8'b011_001_00;
		if (count >= (ITER_MAX >> 3)) return 8'b101_010_01;
		if (count >= (ITER_MAX >> 4)) return 8'b011_001_01;
		if (count >= (ITER_MAX >> 5)) return 8'b001_001_01;
		if (count >= (ITER_MAX >> 6)) return 8'b011_010_10;
		return 8'b010_100_10;
	endfunction

	// RGB332 fields into the top bits
	function automatic logic [23:0] expand_rgb(input color_t c);
		return {c[7:5], 5'b0, c[4:2], 5'b0, c[1:0], 6'b0};
	endfunction

	task automatic build_expected();
		fix_t cr;
		fix_t ci;
		for (int n = 0; n < PIXELS; n++) begin
			cr = fix_t'(X_START_FIX + (n % H_ACTIVE) * STEP_FIX);
			ci = fix_t'(Y_START_FIX - (n / H_ACTIVE) * STEP_FIX);
			expected_rgb[n] = expand_rgb(palette(escape_count(cr, ci)));
		end
	endtask

	////////////////////////////////////////
	// Checks and helpers
	////////////////////////////////////////
	task automatic check_eq(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("MISMATCH %s: expected %h, got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
	endtask

	// Returns on the first sample with the sync low
	task automatic wait_sync_fall(input bit vertical);
		logic prev;
		logic cur;
		prev = vertical ? vsync : hsync;
		cur = prev;
		while (!(prev && !cur)) begin
			prev = cur;
			@(negedge clk);
			cur = vertical ? vsync : hsync;
		end
	endtask

	// From one sync fall to the next one
	task automatic measure_sync(input bit vertical, output int period, output int low_w,
			output int act_n);
		logic prev;
		logic fell;
		period = 0;
		low_w = 0;
		act_n = 0;
		fell = 1'b0;
		while (!fell) begin
			prev = vertical ? vsync : hsync;
			if (!prev) low_w++;
			if (blank_n) act_n++;
			@(negedge clk);
			period++;
			fell = prev && !(vertical ? vsync : hsync);
		end
	endtask

	// Next full frame of active pixels, in raster order
	task automatic capture_frame();
		int n;
		wait_sync_fall(1'b1);
		n = 0;
		while (n < PIXELS) begin
			@(negedge clk);
			if (blank_n) begin
				captured[n] = {red, green, blue};
				n++;
			end
		end
	endtask

	task automatic wait_render_done();
		while (!render_done) @(negedge clk);
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////
	task automatic check_reset_state();
		check_eq("render_done", render_done, 0);
		check_eq("blank_n", blank_n, 0);
		check_eq("rgb", {red, green, blue}, 0);
		check_eq("hsync", hsync, 1);
		check_eq("vsync", vsync, 1);
	endtask

	task automatic check_line_timing();
		int period;
		int low_w;
		int act_n;
		wait_sync_fall(1'b0);
		// Rows 1 and 2, both active
		repeat (2) begin
			measure_sync(1'b0, period, low_w, act_n);
			check_eq("hsync period", period, LINE_CYCLES);
			check_eq("hsync low width", low_w, 3);
			check_eq("blank_n high per line", act_n, H_ACTIVE);
		end
	endtask

	task automatic check_frame_timing();
		int period;
		int low_w;
		int act_n;
		wait_sync_fall(1'b1);
		measure_sync(1'b1, period, low_w, act_n);
		check_eq("vsync period", period, FRAME_CYCLES);
		check_eq("vsync low width", low_w, 2 * LINE_CYCLES);
		check_eq("blank_n high per frame", act_n, PIXELS);
	endtask

	task automatic check_frame_contents();
		wait_render_done();
		capture_frame();
		for (int n = 0; n < PIXELS; n++) begin
			check_eq($sformatf("rgb pixel %0d", n), captured[n], expected_rgb[n]);
		end
		check_eq("render_done after frame", render_done, 1);
	endtask

	task automatic check_restart();
		int delay;
		apply_reset();
		check_eq("render_done after reset", render_done, 0);
		// Somewhere inside the shortest possible render
		delay = 50 + ({$random(seed)} % 600);
		repeat (delay) @(posedge clk);
		@(negedge clk);
		check_eq("render_done mid render", render_done, 0);
		apply_reset();
		check_eq("render_done after restart", render_done, 0);
		wait_render_done();
		capture_frame();
		for (int n = 0; n < PIXELS; n++) begin
			check_eq($sformatf("rgb restart pixel %0d", n), captured[n], expected_rgb[n]);
		end
	endtask

	////////////////////////////////////////
	// Monitors and timeout
	////////////////////////////////////////
	always @(negedge clk) begin
		if (monitor_on) begin
			// Colours dark while blanked
			if (!blank_n) begin
				assert ({red, green, blue} == 24'd0) else begin
					$display("MISMATCH rgb while blanked: expected 000000, got %h",
						{red, green, blue});
					errors++;
				end
			end
			// render_done sticks until reset
			if (reset) begin
				done_seen = 1'b0;
			end else begin
				if (done_seen) begin
					assert (render_done) else begin
						$display("render_done fell without a reset");
						errors++;
					end
				end
				done_seen = render_done;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout, run still going after %0d cycles", CYCLE_LIMIT);
			$display("Checks: %0d, errors: %0d", checks, errors + 1);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		seed = 57;
		reset = 1'b1;
		build_expected();
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		monitor_on = 1'b1;
		check_reset_state();
		check_line_timing();
		check_frame_timing();
		check_frame_contents();
		check_restart();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+common
common/mandel_pkg.sv
render/escape_iterator.sv
render/render_control.sv
verilog/color_map.sv
verilog/frame_buffer.sv
vga/vga_timing.sv
verilog/mandel_top.sv
bench/tb_mandel.sv
